/* Bender.yml */
package:
  name: core_top

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - corePkg.sv
      - regFile.sv
      - alu.sv
      - dataPath.sv
      - controlUnit.sv
      - instrMem.sv
      - coreTop.sv
  - target: test
    include_dirs:
      - .
    files:
      - coreTop_checker.sv
      - coreTop_tb.sv

/* alu.sv */
`include "core_macros.svh"

module alu (
    input  corePkg::aluOpT              i_aluOp,
    input  logic [`CORE_DATA_WIDTH-1:0] i_a,
    input  logic [`CORE_DATA_WIDTH-1:0] i_b,
    output logic [`CORE_DATA_WIDTH-1:0] o_result
);
    import corePkg::*;

    // sum and difference drop the carry out of the top bit.
    always_comb begin
        case (i_aluOp)
            ADD: begin
                o_result = i_a + i_b;
            end
            SUB: begin
                o_result = i_a - i_b;
            end
            AND: begin
                o_result = i_a & i_b;
            end
            OR: begin
                o_result = i_a | i_b;
            end
            XOR: begin
                o_result = i_a ^ i_b;
            end
            NOT: begin
                o_result = ~i_a;
            end
            default: begin
                o_result = '0;
            end
        endcase
    end

endmodule

/* controlUnit.sv */
`include "core_macros.svh"

module controlUnit (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            i_start,
    input  corePkg::instrT                  i_fetchData,
    input  logic                            i_greaterThan,
    output logic [`CORE_PC_WIDTH-1:0]       o_fetchAddr,
    output logic                            o_running,
    output logic                            o_wSrcImm,
    output logic [`CORE_DATA_WIDTH-1:0]     o_imm,
    output logic [`CORE_REG_ADDR_WIDTH-1:0] o_readAddr1,
    output logic [`CORE_REG_ADDR_WIDTH-1:0] o_readAddr2,
    output logic [`CORE_REG_ADDR_WIDTH-1:0] o_writeAddr,
    output logic                            o_writeEn,
    output corePkg::aluOpT                  o_aluOp,
    output logic                            o_outLoad
);
    import corePkg::*;

    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        EXECUTE
    } stateT;

    stateT                     state;
    stateT                     stateNext;
    logic [`CORE_PC_WIDTH-1:0] pc;
    logic [`CORE_PC_WIDTH-1:0] pcNext;
    instrT                     instr;
    opcodeT                    opcode;
    logic                      isExecute;

    assign opcode    = instr.rType.opcode;
    assign isExecute = (state == EXECUTE);

    always_comb begin
        case (state)
            IDLE: begin
                stateNext = IDLE;
            end
            FETCH: begin
                stateNext = EXECUTE;
            end
            EXECUTE: begin
                stateNext = (opcode == HALT) ? IDLE : FETCH;
            end
            default: begin
                stateNext = IDLE;
            end
        endcase
        // start wins in every state, so a running program restarts from the top.
        if (i_start) begin
            stateNext = FETCH;
        end
    end

    always_comb begin
        pcNext = pc;
        if (i_start) begin
            pcNext = '0;
        end else if (isExecute && opcode != HALT) begin
            if (opcode == BGT && i_greaterThan) begin
                pcNext = instr.bType.target;
            end else begin
                pcNext = pc + 1'b1;
            end
        end
    end

    // the memory read is issued with the next PC, so the word is ready during FETCH.
    assign o_fetchAddr = pcNext;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= IDLE;
            pc    <= '0;
        end else begin
            state <= stateNext;
            pc    <= pcNext;
        end
    end

    always_ff @(posedge clk) begin
        if (state == FETCH) begin
            instr <= i_fetchData;
        end
    end

    assign o_running = (state != IDLE);

    // OUT reads its register through the first source field of the r view.
    always_comb begin
        o_readAddr1 = instr.rType.rs1;
        o_readAddr2 = instr.rType.rs2;
        if (opcode == BGT) begin
            o_readAddr1 = instr.bType.rs1;
            o_readAddr2 = instr.bType.rs2;
        end
    end

    // rd sits in the same bits in the r and i views.
    assign o_writeAddr = instr.rType.rd;
    assign o_wSrcImm   = (opcode == LDI);
    assign o_imm       = instr.iType.imm;
    assign o_aluOp     = instr.rType.aluOp;
    assign o_writeEn   = isExecute && (opcode == ALU || opcode == LDI);
    assign o_outLoad   = isExecute && (opcode == OUT);

endmodule

/* corePkg.sv */
`include "core_macros.svh"

package corePkg;

    typedef enum logic [`CORE_OPCODE_WIDTH-1:0] {
        NOP  = 4'd0,
        ALU  = 4'd1,
        LDI  = 4'd2,
        OUT  = 4'd3,
        BGT  = 4'd4,
        HALT = 4'd5
    } opcodeT;

    // codes 6 and 7 are left unnamed and produce zero.
    typedef enum logic [`CORE_ALUOP_WIDTH-1:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        XOR = 3'd4,
        NOT = 3'd5
    } aluOpT;

    typedef struct packed {
        opcodeT                          opcode;
        logic [`CORE_REG_ADDR_WIDTH-1:0] rd;
        logic [`CORE_REG_ADDR_WIDTH-1:0] rs1;
        logic [`CORE_REG_ADDR_WIDTH-1:0] rs2;
        aluOpT                           aluOp;
    } rTypeT;

    typedef struct packed {
        opcodeT                          opcode;
        logic [`CORE_REG_ADDR_WIDTH-1:0] rd;
        logic [`CORE_DATA_WIDTH-1:0]     imm;
        logic                            unused;
    } iTypeT;

    typedef struct packed {
        opcodeT                          opcode;
        logic [`CORE_REG_ADDR_WIDTH-1:0] rs1;
        logic [`CORE_REG_ADDR_WIDTH-1:0] rs2;
        logic [`CORE_PC_WIDTH-1:0]       target;
    } bTypeT;

    // every view shares the opcode in the top four bits.
    typedef union packed {
        rTypeT rType;
        iTypeT iType;
        bTypeT bType;
    } instrT;

endpackage

/* coreTop.sv */
`include "core_macros.svh"

module coreTop (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          i_wbCyc,
    input  logic                          i_wbStb,
    input  logic                          i_wbWe,
    input  logic [`CORE_WB_ADR_WIDTH-1:0] i_wbAdr,
    input  logic [`CORE_INSTR_WIDTH-1:0]  i_wbDatI,
    output logic [`CORE_INSTR_WIDTH-1:0]  o_wbDatO,
    output logic                          o_wbAck,
    output logic [`CORE_DATA_WIDTH-1:0]   o_outPort,
    output logic                          o_outStrobe
);
    import corePkg::*;

    logic                            start;
    logic                            running;
    logic [`CORE_PC_WIDTH-1:0]       fetchAddr;
    instrT                           fetchData;
    logic                            greaterThan;
    logic                            wSrcImm;
    logic [`CORE_DATA_WIDTH-1:0]     imm;
    logic [`CORE_REG_ADDR_WIDTH-1:0] readAddr1;
    logic [`CORE_REG_ADDR_WIDTH-1:0] readAddr2;
    logic [`CORE_REG_ADDR_WIDTH-1:0] writeAddr;
    logic                            writeEn;
    aluOpT                           aluOp;
    logic                            outLoad;

    instrMem instrMem_i (
        .clk         (clk),
        .reset       (reset),
        .i_wbCyc     (i_wbCyc),
        .i_wbStb     (i_wbStb),
        .i_wbWe      (i_wbWe),
        .i_wbAdr     (i_wbAdr),
        .i_wbDatI    (i_wbDatI),
        .i_running   (running),
        .i_fetchAddr (fetchAddr),
        .o_wbDatO    (o_wbDatO),
        .o_wbAck     (o_wbAck),
        .o_start     (start),
        .o_fetchData (fetchData)
    );

    controlUnit controlUnit_i (
        .clk           (clk),
        .reset         (reset),
        .i_start       (start),
        .i_fetchData   (fetchData),
        .i_greaterThan (greaterThan),
        .o_fetchAddr   (fetchAddr),
        .o_running     (running),
        .o_wSrcImm     (wSrcImm),
        .o_imm         (imm),
        .o_readAddr1   (readAddr1),
        .o_readAddr2   (readAddr2),
        .o_writeAddr   (writeAddr),
        .o_writeEn     (writeEn),
        .o_aluOp       (aluOp),
        .o_outLoad     (outLoad)
    );

    dataPath dataPath_i (
        .clk           (clk),
        .reset         (reset),
        .i_wSrcImm     (wSrcImm),
        .i_imm         (imm),
        .i_readAddr1   (readAddr1),
        .i_readAddr2   (readAddr2),
        .i_writeAddr   (writeAddr),
        .i_writeEn     (writeEn),
        .i_aluOp       (aluOp),
        .i_outLoad     (outLoad),
        .o_greaterThan (greaterThan),
        .o_outPort     (o_outPort),
        .o_outStrobe   (o_outStrobe)
    );

endmodule

/* coreTop_checker.sv */
`include "core_macros.svh"

module coreTop_checker (
    input logic                        clk,
    input logic                        reset,
    input logic                        i_wbCyc,
    input logic                        i_wbStb,
    input logic                        i_wbAck,
    input logic [`CORE_DATA_WIDTH-1:0] i_outPort,
    input logic                        i_outStrobe
);
    timeunit 1ns;
    timeprecision 1ps;

    // number of assertion failures seen so far.
    int failCount = 0;

    property ackAfterRequest;
        @(posedge clk) disable iff (reset) i_wbAck |-> $past(i_wbCyc && i_wbStb);
    endproperty

    property ackSingleCycle;
        @(posedge clk) disable iff (reset) i_wbAck |=> !i_wbAck;
    endproperty

    property strobeSingleCycle;
        @(posedge clk) disable iff (reset) i_outStrobe |=> !i_outStrobe;
    endproperty

    // a new port value always comes with a fresh strobe.
    property portChangesWithStrobe;
        @(posedge clk) disable iff (reset) $changed(i_outPort) |-> $rose(i_outStrobe);
    endproperty

    ackAfterRequestA: assert property (ackAfterRequest) else begin
        $error("Wishbone ack without a request in the previous cycle");
        failCount++;
    end

    ackSingleCycleA: assert property (ackSingleCycle) else begin
        $error("Wishbone ack high in two consecutive cycles");
        failCount++;
    end

    strobeSingleCycleA: assert property (strobeSingleCycle) else begin
        $error("output strobe high in two consecutive cycles");
        failCount++;
    end

    portChangesWithStrobeA: assert property (portChangesWithStrobe) else begin
        $error("output port changed without a rising strobe");
        failCount++;
    end

endmodule

/* coreTop_tb.sv */
`include "core_macros.svh"

module coreTop_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int clkPeriod = 4;
    localparam int resetCycles = 4;
    localparam int wbCycles = 4;
    localparam int countN = 5;
    localparam logic [`CORE_WB_ADR_WIDTH-1:0] ctrlAddr = `CORE_CTRL_ADDR;
    localparam logic [3:0] opAlu = 4'd1;
    localparam logic [3:0] opLdi = 4'd2;
    localparam logic [3:0] opOut = 4'd3;
    localparam logic [3:0] opBgt = 4'd4;
    localparam logic [3:0] opHalt = 4'd5;
    localparam logic [15:0] haltWord = {opHalt, 12'h000};

    // loading, starting and polling, plus two cycles per executed instruction.
    function automatic int runCycles(input int words, input int instrs);
        return (words + 3) * wbCycles + 2 * instrs;
    endfunction

    localparam int watchdogCycles = resetCycles + (2 * `CORE_IMEM_DEPTH + 1) * wbCycles
        + runCycles(9, 9) + 8 * runCycles(5, 5) + runCycles(6, 6)
        + runCycles(6, 3 * countN + 3) + runCycles(3, 3) + runCycles(4, 4) + 200;

    logic                          clk;
    logic                          reset;
    logic                          wbCyc;
    logic                          wbStb;
    logic                          wbWe;
    logic [`CORE_WB_ADR_WIDTH-1:0] wbAdr;
    logic [`CORE_INSTR_WIDTH-1:0]  wbDatI;
    logic [`CORE_INSTR_WIDTH-1:0]  wbDatO;
    logic                          wbAck;
    logic [`CORE_DATA_WIDTH-1:0]   outPort;
    logic                          outStrobe;

    logic [15:0] progWords[$];
    logic [15:0] progImage [`CORE_IMEM_DEPTH];
    logic [7:0]  modelRegs [`CORE_REG_COUNT];
    logic [7:0]  expQ[$];
    logic [7:0]  outQ[$];

    coreTop coreTop_i (
        .clk         (clk),
        .reset       (reset),
        .i_wbCyc     (wbCyc),
        .i_wbStb     (wbStb),
        .i_wbWe      (wbWe),
        .i_wbAdr     (wbAdr),
        .i_wbDatI    (wbDatI),
        .o_wbDatO    (wbDatO),
        .o_wbAck     (wbAck),
        .o_outPort   (outPort),
        .o_outStrobe (outStrobe)
    );

    bind coreTop coreTop_checker checker_i (
        .clk         (clk),
        .reset       (reset),
        .i_wbCyc     (i_wbCyc),
        .i_wbStb     (i_wbStb),
        .i_wbAck     (o_wbAck),
        .i_outPort   (o_outPort),
        .i_outStrobe (o_outStrobe)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(clkPeriod / 2) clk = ~clk;
        end
    end

    always @(negedge clk) begin
        if (outStrobe) begin
            outQ.push_back(outPort);
        end
    end

    task automatic failRun(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    always @(coreTop_i.checker_i.failCount) begin
        if (coreTop_i.checker_i.failCount != 0) begin
            failRun("a concurrent assertion in the checker failed");
        end
    end

    task automatic checkValue(input string name, input int expected, input int actual);
        assert (expected == actual) else begin
            failRun($sformatf("Fail %s: expected 0x%0h, actual 0x%0h", name, expected, actual));
        end
    endtask

    function automatic logic [15:0] encAlu(input int rd, input int rs1, input int rs2, input int op);
        return {opAlu, 3'(rd), 3'(rs1), 3'(rs2), 3'(op)};
    endfunction

    function automatic logic [15:0] encLdi(input int rd, input int imm);
        return {opLdi, 3'(rd), 8'(imm), 1'b0};
    endfunction

    function automatic logic [15:0] encOut(input int rs);
        return {opOut, 3'b000, 3'(rs), 6'b000000};
    endfunction

    function automatic logic [15:0] encBgt(input int rs1, input int rs2, input int target);
        return {opBgt, 3'(rs1), 3'(rs2), 6'(target)};
    endfunction

    function automatic logic [7:0] readReg(input logic [2:0] idx);
        return (idx == 3'd0) ? 8'h00 : modelRegs[idx];
    endfunction

    // reference model of the instruction set, run over the program image.
    task automatic modelRun();
        int          pc;
        int          steps;
        logic [15:0] w;
        logic [7:0]  a;
        logic [7:0]  b;
        expQ.delete();
        pc = 0;
        steps = 0;
        w = progImage[0];
        while (w[15:12] != opHalt && steps < 1000) begin
            a = readReg(w[8:6]);
            b = readReg(w[5:3]);
            pc = (pc + 1) % `CORE_IMEM_DEPTH;
            case (w[15:12])
                opAlu: begin
                    case (w[2:0])
                        3'd0: modelRegs[w[11:9]] = a + b;
                        3'd1: modelRegs[w[11:9]] = a - b;
                        3'd2: modelRegs[w[11:9]] = a & b;
                        3'd3: modelRegs[w[11:9]] = a | b;
                        3'd4: modelRegs[w[11:9]] = a ^ b;
                        3'd5: modelRegs[w[11:9]] = ~a;
                        default: modelRegs[w[11:9]] = 8'h00;
                    endcase
                end
                opLdi: modelRegs[w[11:9]] = w[8:1];
                opOut: expQ.push_back(a);
                opBgt: begin
                    if (readReg(w[11:9]) > readReg(w[8:6])) begin
                        pc = w[5:0];
                    end
                end
                default: begin
                end
            endcase
            w = progImage[pc];
            steps++;
        end
    endtask

    task automatic waitAck();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!wbAck) begin
            waited++;
            if (waited > 16) begin
                failRun("no Wishbone acknowledge within 16 cycles");
            end
            @(negedge clk);
        end
    endtask

    task automatic wbWrite(input logic [`CORE_WB_ADR_WIDTH-1:0] adr, input logic [15:0] data);
        @(posedge clk);
        wbCyc <= 1'b1;
        wbStb <= 1'b1;
        wbWe <= 1'b1;
        wbAdr <= adr;
        wbDatI <= data;
        waitAck();
        @(posedge clk);
        wbCyc <= 1'b0;
        wbStb <= 1'b0;
        wbWe <= 1'b0;
    endtask

    task automatic wbRead(input logic [`CORE_WB_ADR_WIDTH-1:0] adr, output logic [15:0] data);
        @(posedge clk);
        wbCyc <= 1'b1;
        wbStb <= 1'b1;
        wbWe <= 1'b0;
        wbAdr <= adr;
        waitAck();
        data = wbDatO;
        @(posedge clk);
        wbCyc <= 1'b0;
        wbStb <= 1'b0;
    endtask

    task automatic loadProgram();
        for (int i = 0; i < progWords.size(); i++) begin
            wbWrite(i, progWords[i]);
            progImage[i] = progWords[i];
        end
    endtask

    task automatic runProgram(input string name);
        logic [15:0] status;
        int          polls;
        outQ.delete();
        wbWrite(ctrlAddr, 16'h0001);
        status = 16'h0001;
        polls = 0;
        while (status[0]) begin
            wbRead(ctrlAddr, status);
            polls++;
            if (polls > 500) begin
                failRun("core still running after 500 status reads");
            end
        end
        checkValue({name, " status"}, 0, status);
    endtask

    task automatic runAndCheck(input string name);
        loadProgram();
        modelRun();
        runProgram(name);
        checkValue({name, " count"}, expQ.size(), outQ.size());
        for (int i = 0; i < expQ.size(); i++) begin
            checkValue($sformatf("%s out%0d", name, i), expQ[i], outQ[i]);
        end
    endtask

    task automatic testMemReadback();
        logic [15:0] words [`CORE_IMEM_DEPTH];
        logic [15:0] got;
        wbRead(ctrlAddr, got);
        checkValue("memReadback status", 0, got);
        for (int i = 0; i < `CORE_IMEM_DEPTH; i++) begin
            words[i] = 16'($urandom);
            wbWrite(i, words[i]);
            progImage[i] = words[i];
        end
        for (int i = 0; i < `CORE_IMEM_DEPTH; i++) begin
            wbRead(i, got);
            checkValue($sformatf("memReadback word%0d", i), words[i], got);
        end
    endtask

    task automatic testLdiOut();
        progWords = '{encLdi(1, 8'h11), encLdi(2, 8'h22), encLdi(3, 8'hA5), encLdi(7, 8'hF0),
                      encOut(7), encOut(1), encOut(3), encOut(2), haltWord};
        runAndCheck("ldiOut");
        checkValue("ldiOut first", 8'hF0, outQ[0]);
    endtask

    task automatic testAluOps();
        int a;
        int b;
        for (int op = 0; op < 8; op++) begin
            a = $urandom % 256;
            b = $urandom % 256;
            progWords = '{encLdi(1, a), encLdi(2, b), encAlu(3, 1, 2, op), encOut(3), haltWord};
            runAndCheck($sformatf("aluOp%0d", op));
        end
    endtask

    task automatic testRegZero();
        progWords = '{encLdi(0, 8'h5A), encOut(0), encLdi(4, 8'h3C), encAlu(5, 0, 4, 0),
                      encOut(5), haltWord};
        runAndCheck("regZero");
        checkValue("regZero r0", 0, outQ[0]);
    endtask

    task automatic testCountdown();
        progWords = '{encLdi(1, countN), encLdi(2, 1), encOut(1), encAlu(1, 1, 2, 1),
                      encBgt(1, 0, 2), haltWord};
        runAndCheck("countdown");
        checkValue("countdown length", countN, outQ.size());
    endtask

    // the second program relies on r4 and r5 from the first one.
    task automatic testRestart();
        progWords = '{encLdi(4, 8'h37), encLdi(5, 8'hD4), haltWord};
        runAndCheck("restart first");
        progWords = '{encAlu(6, 4, 5, 0), encOut(6), encOut(5), haltWord};
        runAndCheck("restart second");
        checkValue("restart sum", 8'h0B, outQ[0]);
    endtask

    initial begin
        #(watchdogCycles * clkPeriod);
        failRun($sformatf("watchdog expired after %0d cycles", watchdogCycles));
    end

    initial begin
        void'($urandom(97260));
        reset = 1'b1;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
        wbAdr = '0;
        wbDatI = '0;
        for (int i = 0; i < `CORE_REG_COUNT; i++) begin
            modelRegs[i] = 8'h00;
        end
        repeat (resetCycles) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        checkValue("reset outPort", 0, outPort);
        checkValue("reset strobe", 0, outStrobe);
        checkValue("reset ack", 0, wbAck);
        testMemReadback();
        testLdiOut();
        testAluOps();
        testRegZero();
        testCountdown();
        testRestart();
        if (coreTop_i.checker_i.failCount == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("%0d concurrent assertion failures", coreTop_i.checker_i.failCount);
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* core_macros.svh */
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// register and ALU word width.
`define CORE_DATA_WIDTH 8

// instruction word width, which is also the Wishbone data width.
`define CORE_INSTR_WIDTH 16

`define CORE_REG_COUNT 8
`define CORE_REG_ADDR_WIDTH ($clog2(`CORE_REG_COUNT))

// program memory depth and the program counter that walks it.
`define CORE_IMEM_DEPTH 64
`define CORE_PC_WIDTH ($clog2(`CORE_IMEM_DEPTH))

// the control/status word sits just above the program words.
`define CORE_CTRL_ADDR 64
`define CORE_WB_ADR_WIDTH (`CORE_PC_WIDTH + 1)

`define CORE_OPCODE_WIDTH 4
`define CORE_ALUOP_WIDTH 3

`endif

/* dataPath.sv */
`include "core_macros.svh"

module dataPath (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            i_wSrcImm,
    input  logic [`CORE_DATA_WIDTH-1:0]     i_imm,
    input  logic [`CORE_REG_ADDR_WIDTH-1:0] i_readAddr1,
    input  logic [`CORE_REG_ADDR_WIDTH-1:0] i_readAddr2,
    input  logic [`CORE_REG_ADDR_WIDTH-1:0] i_writeAddr,
    input  logic                            i_writeEn,
    input  corePkg::aluOpT                  i_aluOp,
    input  logic                            i_outLoad,
    output logic                            o_greaterThan,
    output logic [`CORE_DATA_WIDTH-1:0]     o_outPort,
    output logic                            o_outStrobe
);

    logic [`CORE_DATA_WIDTH-1:0] rData1;
    logic [`CORE_DATA_WIDTH-1:0] rData2;
    logic [`CORE_DATA_WIDTH-1:0] aluResult;
    logic [`CORE_DATA_WIDTH-1:0] wData;

    // write source is either the ALU result or the instruction immediate.
    assign wData = i_wSrcImm ? i_imm : aluResult;

    regFile regFile_i (
        .clk         (clk),
        .i_readAddr1 (i_readAddr1),
        .i_readAddr2 (i_readAddr2),
        .i_writeAddr (i_writeAddr),
        .i_writeEn   (i_writeEn),
        .i_wData     (wData),
        .o_rData1    (rData1),
        .o_rData2    (rData2)
    );

    alu alu_i (
        .i_aluOp  (i_aluOp),
        .i_a      (rData1),
        .i_b      (rData2),
        .o_result (aluResult)
    );

    // unsigned compare of the two read ports, used by BGT.
    assign o_greaterThan = (rData1 > rData2);

    // the strobe follows the load by one cycle, so it lines up with the new port value.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            o_outPort   <= '0;
            o_outStrobe <= 1'b0;
        end else begin
            o_outStrobe <= i_outLoad;
            if (i_outLoad) begin
                o_outPort <= rData1;
            end
        end
    end

endmodule

/* instrMem.sv */
`include "core_macros.svh"

module instrMem (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          i_wbCyc,
    input  logic                          i_wbStb,
    input  logic                          i_wbWe,
    input  logic [`CORE_WB_ADR_WIDTH-1:0] i_wbAdr,
    input  logic [`CORE_INSTR_WIDTH-1:0]  i_wbDatI,
    input  logic                          i_running,
    input  logic [`CORE_PC_WIDTH-1:0]     i_fetchAddr,
    output logic [`CORE_INSTR_WIDTH-1:0]  o_wbDatO,
    output logic                          o_wbAck,
    output logic                          o_start,
    output corePkg::instrT                o_fetchData
);

    logic [`CORE_INSTR_WIDTH-1:0] mem [`CORE_IMEM_DEPTH];
    logic                         accept;
    logic                         selMem;
    logic                         selCtrl;

    // a request is taken only while ack is low, which keeps ack to one cycle.
    assign accept  = i_wbCyc && i_wbStb && !o_wbAck;
    assign selMem  = (i_wbAdr < `CORE_IMEM_DEPTH);
    assign selCtrl = (i_wbAdr == `CORE_CTRL_ADDR);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            o_wbAck <= 1'b0;
            o_start <= 1'b0;
        end else begin
            o_wbAck <= accept;
            o_start <= accept && i_wbWe && selCtrl && i_wbDatI[0];
        end
    end

    always_ff @(posedge clk) begin
        if (accept && i_wbWe && selMem) begin
            mem[i_wbAdr[`CORE_PC_WIDTH-1:0]] <= i_wbDatI;
        end
        if (accept && !i_wbWe) begin
            if (selMem) begin
                o_wbDatO <= mem[i_wbAdr[`CORE_PC_WIDTH-1:0]];
            end else if (selCtrl) begin
                o_wbDatO <= {{(`CORE_INSTR_WIDTH - 1){1'b0}}, i_running};
            end else begin
                o_wbDatO <= '0;
            end
        end
    end

    // fetch port reads every cycle.
    always_ff @(posedge clk) begin
        o_fetchData <= mem[i_fetchAddr];
    end

endmodule

/* regFile.sv */
`include "core_macros.svh"

module regFile (
    input  logic                            clk,
    input  logic [`CORE_REG_ADDR_WIDTH-1:0] i_readAddr1,
    input  logic [`CORE_REG_ADDR_WIDTH-1:0] i_readAddr2,
    input  logic [`CORE_REG_ADDR_WIDTH-1:0] i_writeAddr,
    input  logic                            i_writeEn,
    input  logic [`CORE_DATA_WIDTH-1:0]     i_wData,
    output logic [`CORE_DATA_WIDTH-1:0]     o_rData1,
    output logic [`CORE_DATA_WIDTH-1:0]     o_rData2
);

    logic [`CORE_DATA_WIDTH-1:0] regs [`CORE_REG_COUNT];

    always_ff @(posedge clk) begin
        if (i_writeEn) begin
            regs[i_writeAddr] <= i_wData;
        end
    end

    // register 0 is stored like the others but always reads as zero.
    always_comb begin
        if (i_readAddr1 == '0) begin
            o_rData1 = '0;
        end else begin
            o_rData1 = regs[i_readAddr1];
        end
    end

    always_comb begin
        if (i_readAddr2 == '0) begin
            o_rData2 = '0;
        end else begin
            o_rData2 = regs[i_readAddr2];
        end
    end

endmodule

/* sim.f */
+incdir+.
corePkg.sv
regFile.sv
alu.sv
dataPath.sv
controlUnit.sv
instrMem.sv
coreTop.sv
coreTop_checker.sv
coreTop_tb.sv
